//--- verilog/shifterPkg.sv
package shifterPkg;

    // Data path width of the unit. The count and the barrel depth follow from it.
    localparam int WordWidth = 32;
    localparam int AmountWidth = $clog2(WordWidth);

    // Bit positions inside the status vector.
    localparam int FlagN = 2;
    localparam int FlagZ = 1;
    localparam int FlagC = 0;

    typedef logic [WordWidth-1:0] shiftWord;

    typedef logic [AmountWidth-1:0] shiftAmount;

    typedef logic [2:0] statusFlags;    // N, Z, C from the top bit down.

    // Encodings follow the ARM shift type field.
    typedef enum logic [1:0] {
        LSL = 2'b00,
        LSR = 2'b01,
        ASR = 2'b10,
        ROR = 2'b11
    } shiftOpSel;

endpackage

//--- verilog/shiftStage.sv
module shiftStage #(
    parameter int DataWidth = 32,
    parameter int Distance = 1
) (
    input  shifterPkg::shiftOpSel  shiftOp,
    input  logic                   shift,
    input  logic [DataWidth-1:0]   dataIn,
    input  logic                   carryIn,
    output logic [DataWidth-1:0]   dataOut,
    output logic                   carryOut
);

    logic [DataWidth-1:0] shiftedLeft;
    logic [DataWidth-1:0] shiftedRight;
    logic [DataWidth-1:0] rotated;
    logic                 fillBit;
    logic                 lastOutLeft;
    logic                 lastOutRight;

    if (Distance < 1 || Distance >= DataWidth) begin : gBadDistance
        $error("shiftStage distance %0d is out of range for width %0d", Distance, DataWidth);
    end

    // Zero fill for LSR, copies of the sign bit for ASR.
    assign fillBit = (shiftOp == shifterPkg::ASR) && dataIn[DataWidth-1];

    assign shiftedLeft  = dataIn << Distance;
    assign shiftedRight = {{Distance{fillBit}}, dataIn[DataWidth-1:Distance]};
    assign rotated      = {dataIn[Distance-1:0], dataIn[DataWidth-1:Distance]};

    // Last bit to leave the word in each direction.
    assign lastOutLeft  = dataIn[DataWidth-Distance];
    assign lastOutRight = dataIn[Distance-1];

    always_comb begin
        dataOut  = dataIn;
        carryOut = carryIn;
        if (shift) begin
            case (shiftOp)
                shifterPkg::LSL: begin
                    dataOut  = shiftedLeft;
                    carryOut = lastOutLeft;
                end
                shifterPkg::LSR,
                shifterPkg::ASR: begin
                    dataOut  = shiftedRight;
                    carryOut = lastOutRight;
                end
                shifterPkg::ROR: begin
                    dataOut  = rotated;
                    carryOut = lastOutRight;    // Same bit as the new MSB.
                end
                default: begin
                    dataOut  = dataIn;
                    carryOut = carryIn;
                end
            endcase
        end
    end

endmodule

//--- verilog/shifter.sv
module shifter #(
    parameter int DataWidth = 32
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           start,
    input  shifterPkg::shiftOpSel          shiftOp,
    input  logic [$clog2(DataWidth)-1:0]   shiftCount,
    input  logic                           carryIn,
    input  logic [DataWidth-1:0]           operand,
    output logic [DataWidth-1:0]           result,
    output logic                           resultCarry,
    output logic                           done
);

    localparam int CountWidth = $clog2(DataWidth);

    shifterPkg::shiftOpSel    opReg;
    logic [CountWidth-1:0]    countReg;
    logic                     carryReg;
    logic [DataWidth-1:0]     operandReg;
    logic                     validReg;

    // Stage i feeds stage i+1. Entry 0 is the registered operand.
    logic [DataWidth-1:0]     stageData [CountWidth+1];
    logic                     stageCarry [CountWidth+1];

    // First pipeline step. carryIn is taken as it stands at the start edge.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            validReg <= 1'b0;
        end else begin
            validReg <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            opReg      <= shiftOp;
            countReg   <= shiftCount;
            carryReg   <= carryIn;
            operandReg <= operand;
        end
    end

    assign stageData[0]  = operandReg;
    assign stageCarry[0] = carryReg;

    // Distances 1, 2, 4 and so on, one count bit each.
    for (genvar i = 0; i < CountWidth; i++) begin : gStage
        shiftStage #(
            .DataWidth (DataWidth),
            .Distance  (1 << i)
        ) i_stage (
            .shiftOp  (opReg),
            .shift    (countReg[i]),
            .dataIn   (stageData[i]),
            .carryIn  (stageCarry[i]),
            .dataOut  (stageData[i+1]),
            .carryOut (stageCarry[i+1])
        );
    end

    // Second pipeline step.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= validReg;
        end
    end

    always_ff @(posedge clk) begin
        if (validReg) begin
            result      <= stageData[CountWidth];
            resultCarry <= stageCarry[CountWidth];
        end
    end

    opKnownOnStart: assert property (
        @(posedge clk) disable iff (reset)
        start |-> !$isunknown(shiftOp)
    );

    doneFollowsStart: assert property (
        @(posedge clk) disable iff (reset)
        start |-> ##2 done
    );

    doneOnlyAfterStart: assert property (
        @(posedge clk) disable iff (reset)
        done |-> $past(start, 2)
    );

endmodule

//--- verilog/shiftFlags.sv
module shiftFlags (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   setFlags,
    input  logic                   done,
    input  shifterPkg::shiftWord   result,
    input  logic                   resultCarry,
    output shifterPkg::statusFlags flags,
    output logic                   carryFlag
);

    localparam int MsbIndex = $bits(shifterPkg::shiftWord) - 1;

    logic [1:0] setPipe;    // Tracks the shifter's two pipeline steps.
    logic       update;
    logic       zeroResult;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            setPipe <= '0;
        end else begin
            setPipe <= {setPipe[0], start & setFlags};
        end
    end

    assign update     = done & setPipe[1];
    assign zeroResult = (result == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flags <= '0;
        end else if (update) begin
            flags[shifterPkg::FlagN] <= result[MsbIndex];
            flags[shifterPkg::FlagZ] <= zeroResult;
            flags[shifterPkg::FlagC] <= resultCarry;
        end
    end

    // Feeds the carry-in of the next shift.
    assign carryFlag = flags[shifterPkg::FlagC];

    // The request must arrive in the same cycle as the shifter's done.
    requestMatchesDone: assert property (
        @(posedge clk) disable iff (reset)
        setPipe[1] |-> done
    );

    flagsChangeAfterDone: assert property (
        @(posedge clk) disable iff (reset)
        !$stable(flags) |-> $past(done)
    );

endmodule

//--- verilog/shiftUnit.sv
module shiftUnit #(
    parameter int DataWidth = shifterPkg::WordWidth
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic                    setFlags,
    input  shifterPkg::shiftOpSel   shiftOp,
    input  shifterPkg::shiftAmount  shiftCount,
    input  shifterPkg::shiftWord    operand,
    output shifterPkg::shiftWord    result,
    output logic                    resultCarry,
    output logic                    done,
    output shifterPkg::statusFlags  flags
);

    logic carryFlag;

    // The word type fixes the port width, so the two have to agree.
    if (DataWidth != $bits(shifterPkg::shiftWord)) begin : gWidthMismatch
        $error("shiftUnit width %0d differs from the package word width", DataWidth);
    end

    shifter #(
        .DataWidth (DataWidth)
    ) i_shifter (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .shiftOp     (shiftOp),
        .shiftCount  (shiftCount),
        .carryIn     (carryFlag),
        .operand     (operand),
        .result      (result),
        .resultCarry (resultCarry),
        .done        (done)
    );

    shiftFlags i_shiftFlags (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .setFlags    (setFlags),
        .done        (done),
        .result      (result),
        .resultCarry (resultCarry),
        .flags       (flags),
        .carryFlag   (carryFlag)
    );

endmodule

//--- tb/shiftModel.svh
`ifndef SHIFT_MODEL_SVH
`define SHIFT_MODEL_SVH

localparam int ModelWidth = shifterPkg::WordWidth;

// Result of one shift, taken straight from the operation definitions.
function automatic shifterPkg::shiftWord expectedResult(
    input shifterPkg::shiftOpSel  op,
    input shifterPkg::shiftAmount count,
    input shifterPkg::shiftWord   word
);
    shifterPkg::shiftWord shifted;
    shifted = word;
    case (op)
        shifterPkg::LSL: shifted = word << count;
        shifterPkg::LSR: shifted = word >> count;
        shifterPkg::ASR: shifted = $signed(word) >>> count;    // Sign fill.
        default: begin
            if (count != 0) begin
                shifted = (word >> count) | (word << (ModelWidth - int'(count)));
            end
        end
    endcase
    return shifted;
endfunction

// Carry-out of one shift. A zero count leaves the incoming carry.
function automatic logic expectedCarry(
    input shifterPkg::shiftOpSel  op,
    input shifterPkg::shiftAmount count,
    input shifterPkg::shiftWord   word,
    input logic                   carryIn
);
    int                   n;
    shifterPkg::shiftWord moved;
    n = int'(count);
    if (n == 0) begin
        return carryIn;
    end
    case (op)
        shifterPkg::LSL: moved = word >> (ModelWidth - n);    // Bit 32-n lands in bit 0.
        shifterPkg::LSR,
        shifterPkg::ASR: moved = word >> (n - 1);
        default: moved = expectedResult(op, count, word) >> (ModelWidth - 1);
    endcase
    return moved[0];
endfunction

// N, Z and C after an update request.
function automatic shifterPkg::statusFlags updatedFlags(
    input shifterPkg::shiftWord word,
    input logic                 carry
);
    return {word[ModelWidth-1], word == '0, carry};
endfunction

`endif

//--- tb/shiftUnitTb.sv
module shiftUnitTb;

    timeunit 1ns;
    timeprecision 100ps;

    `include "shiftModel.svh"

    localparam int ResetCycles = 3;
    localparam int SweepCycles = 4 * 4 * 4 + 3;
    localparam int FlagCycles = 6 * 4;
    localparam int ChainLength = 12;
    localparam int ChainCycles = 1 + ChainLength + 18 + 3;
    localparam int RandomCycles = 2600;
    localparam int DrainCycles = 4;
    localparam int CycleLimit = ResetCycles + SweepCycles + FlagCycles + ChainCycles
                                + RandomCycles + DrainCycles + 50;

    localparam shifterPkg::shiftWord Patterns [4] = '{
        32'h8000_0001, 32'hF0F0_1234, 32'h7FFF_FFFE, 32'hA5A5_5A5A
    };
    localparam shifterPkg::shiftAmount SweepCounts [4] = '{5'd0, 5'd1, 5'd16, 5'd31};

    logic                   clk;
    logic                   reset;
    logic                   start;
    logic                   setFlags;
    shifterPkg::shiftOpSel  shiftOp;
    shifterPkg::shiftAmount shiftCount;
    shifterPkg::shiftWord   operand;
    shifterPkg::shiftWord   result;
    logic                   resultCarry;
    logic                   done;
    shifterPkg::statusFlags flags;

    shifterPkg::shiftWord   resultQueue [$];
    logic                   carryQueue [$];
    shifterPkg::statusFlags flagsQueue [$];
    shifterPkg::shiftWord   expResult;
    logic                   expCarry;
    shifterPkg::statusFlags expFlags;
    shifterPkg::statusFlags checkFlags;
    logic                   flagCheck;
    logic [1:0]             startPipe;

    shifterPkg::statusFlags modelFlags;
    shifterPkg::statusFlags flagHistory [3];    // Model flags one, two and three cycles back.
    logic [31:0]            rngState;
    int                     errorCount;
    int                     issuedCount;
    int                     checkedCount;
    int                     cycleCount;

    shiftUnit #(
        .DataWidth (shifterPkg::WordWidth)
    ) i_shiftUnit (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .setFlags    (setFlags),
        .shiftOp     (shiftOp),
        .shiftCount  (shiftCount),
        .operand     (operand),
        .result      (result),
        .resultCarry (resultCarry),
        .done        (done),
        .flags       (flags)
    );

    function automatic logic [31:0] xorshiftStep(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // One clock of stimulus. The shifter sees the flags as they stood three cycles ago.
    task automatic driveCycle(
        input logic                   doStart,
        input shifterPkg::shiftOpSel  op,
        input shifterPkg::shiftAmount count,
        input shifterPkg::shiftWord   word,
        input logic                   update
    );
        shifterPkg::shiftWord expWord;
        logic                 expC;
        @(negedge clk);
        start      = doStart;
        setFlags   = update;
        shiftOp    = op;
        shiftCount = count;
        operand    = word;
        if (doStart) begin
            expWord = expectedResult(op, count, word);
            expC    = expectedCarry(op, count, word, flagHistory[2][0]);
            if (update) begin
                modelFlags = updatedFlags(expWord, expC);
            end
            resultQueue.push_back(expWord);
            carryQueue.push_back(expC);
            flagsQueue.push_back(modelFlags);
            issuedCount++;
        end
        flagHistory[2] = flagHistory[1];
        flagHistory[1] = flagHistory[0];
        flagHistory[0] = modelFlags;
    endtask

    task automatic idleCycles(input int cycles);
        repeat (cycles) driveCycle(1'b0, shifterPkg::LSL, '0, '0, 1'b0);
    endtask

    task automatic reportAndFinish(input logic timedOut);
        $display("Issued %0d operations, checked %0d results, %0d errors",
                 issuedCount, checkedCount, errorCount);
        if (!timedOut && errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Expected values for the operation finishing in this cycle.
    always @(negedge clk) begin
        if (!reset && done) begin
            if (resultQueue.size() == 0) begin
                errorCount++;
                $display("done went high at %0t with no operation in flight", $time);
            end else begin
                expResult = resultQueue.pop_front();
                expCarry  = carryQueue.pop_front();
                expFlags  = flagsQueue.pop_front();
                checkedCount++;
            end
        end
    end

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            startPipe  <= '0;
            flagCheck  <= 1'b0;
            checkFlags <= '0;
        end else begin
            startPipe  <= {startPipe[0], start};
            flagCheck  <= done;    // Flags settle one cycle after done.
            checkFlags <= expFlags;
        end
    end

    resetState: assert property (@(posedge clk) reset |=> (flags == '0 && !done))
        else begin
            errorCount++;
            $display("Flags or done not cleared by reset at %0t", $time);
        end

    doneTiming: assert property (@(posedge clk) disable iff (reset) done == startPipe[1])
        else begin
            errorCount++;
            $display("FAIL %0t done: got %b, expected %b", $time, $sampled(done),
                     $sampled(startPipe[1]));
        end

    resultMatch: assert property (@(posedge clk) disable iff (reset)
        done |-> (result == expResult))
        else begin
            errorCount++;
            $display("FAIL %0t result: got %h, expected %h", $time, $sampled(result),
                     $sampled(expResult));
        end

    carryMatch: assert property (@(posedge clk) disable iff (reset)
        done |-> (resultCarry == expCarry))
        else begin
            errorCount++;
            $display("FAIL %0t resultCarry: got %b, expected %b", $time,
                     $sampled(resultCarry), $sampled(expCarry));
        end

    flagsMatch: assert property (@(posedge clk) disable iff (reset)
        flagCheck |-> (flags == checkFlags))
        else begin
            errorCount++;
            $display("FAIL %0t flags: got %b, expected %b", $time, $sampled(flags),
                     $sampled(checkFlags));
        end

    initial begin
        cycleCount = 0;
        while (cycleCount < CycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles with %0d results checked", cycleCount, checkedCount);
        reportAndFinish(1'b1);
    end

    initial begin
        logic [31:0] draw;
        reset        = 1'b1;
        start        = 1'b0;
        setFlags     = 1'b0;
        shiftOp      = shifterPkg::LSL;
        shiftCount   = '0;
        operand      = '0;
        expResult    = '0;
        expCarry     = 1'b0;
        expFlags     = '0;
        modelFlags   = '0;
        flagHistory  = '{default: '0};
        rngState     = 32'h0e01_6a34;
        errorCount   = 0;
        issuedCount  = 0;
        checkedCount = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Every operation at the edge counts, back to back.
        for (int p = 0; p < 4; p++) begin
            for (int o = 0; o < 4; o++) begin
                for (int c = 0; c < 4; c++) begin
                    driveCycle(1'b1, shifterPkg::shiftOpSel'(o[1:0]), SweepCounts[c],
                               Patterns[p], 1'b1);
                end
            end
        end
        idleCycles(3);

        driveCycle(1'b1, shifterPkg::LSL, 5'd31, 32'h0000_0002, 1'b1);    // All ones out.
        idleCycles(3);
        driveCycle(1'b1, shifterPkg::LSR, 5'd1, 32'h0000_0001, 1'b1);
        idleCycles(3);
        driveCycle(1'b1, shifterPkg::ASR, 5'd16, 32'h8000_0000, 1'b1);
        idleCycles(3);
        driveCycle(1'b1, shifterPkg::LSL, 5'd1, 32'h0000_0001, 1'b0);
        idleCycles(3);
        driveCycle(1'b1, shifterPkg::ROR, 5'd31, 32'h0000_0001, 1'b0);
        idleCycles(3);
        driveCycle(1'b1, shifterPkg::LSR, 5'd4, 32'h0000_0010, 1'b1);
        idleCycles(3);

        // Count-zero shifts pass the carry flag along with varying spacing.
        driveCycle(1'b1, shifterPkg::LSR, 5'd1, 32'h0000_0001, 1'b1);
        for (int i = 0; i < ChainLength; i++) begin
            idleCycles(i % 4);
            driveCycle(1'b1, shifterPkg::shiftOpSel'(i[1:0]), '0,
                       i[0] ? 32'h8000_0000 : 32'h0000_0000, 1'b1);
        end
        idleCycles(3);

        for (int i = 0; i < RandomCycles; i++) begin
            rngState = xorshiftStep(rngState);
            draw     = rngState;
            rngState = xorshiftStep(rngState);
            driveCycle(draw[1:0] != 2'b00, shifterPkg::shiftOpSel'(draw[3:2]), draw[8:4],
                       rngState, draw[9]);
        end
        idleCycles(DrainCycles);

        if (resultQueue.size() != 0) begin
            errorCount++;
            $display("%0d operations never signalled done", resultQueue.size());
        end
        reportAndFinish(1'b0);
    end

endmodule

//--- verilog.f
+incdir+tb
verilog/shifterPkg.sv
verilog/shiftStage.sv
verilog/shifter.sv
verilog/shiftFlags.sv
verilog/shiftUnit.sv
tb/shiftUnitTb.sv

//--- Makefile
VERILATOR    := verilator
TOP          := shiftUnitTb
FILELIST     := verilog.f
OBJDIR       := obj_dir
COMMONFLAGS  := --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)
LINTFLAGS    := --lint-only
SIMFLAGS     := --binary -j 0 -Mdir $(OBJDIR)
PASSMSG      := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) $(COMMONFLAGS)

# The run passes only when the pass message shows up in the output.
sim:
	$(VERILATOR) $(SIMFLAGS) $(COMMONFLAGS)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)
